// File: logic/lsu_cfg.svh
// lsu configuration
// widths and limits shared by the load/store unit blocks

`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data path
`define LSU_DATA_W 32          // data and address width
`define LSU_BE_W 4             // byte lanes per word
`define LSU_OFFS_W 2           // byte offset inside a word

// transaction tracking
`define LSU_MAX_OUTSTANDING 2  // accepted but unanswered accesses
`define LSU_CNT_W 2            // width of the outstanding counter

`endif

// File: logic/lsu_pkg.sv
// lsu types
// enums and packed structs passed between the load/store unit blocks

`include "lsu_cfg.svh"

package lsu_pkg;

  // access size, encoding as seen from the execute stage
  typedef enum logic [1:0] {
    dt_word = 2'b00,
    dt_half = 2'b01,
    dt_byte = 2'b10
  } data_type_e;

  // upper-bit fill for loads narrower than a word
  typedef enum logic [1:0] {
    ext_zero = 2'b00,
    ext_sign = 2'b01,
    ext_ones = 2'b10
  } ext_mode_e;

  typedef enum logic {
    port_idle     = 1'b0,
    port_wait_gnt = 1'b1   // request on the bus, no grant yet
  } port_state_e;

  // one load or store from the execute stage
  typedef struct packed {
    logic                   we;
    data_type_e             dtype;
    ext_mode_e              ext;
    logic [`LSU_DATA_W-1:0] op_a;      // base
    logic [`LSU_DATA_W-1:0] op_b;      // offset
    logic                   use_incr;  // add op_b to the base
    logic [`LSU_DATA_W-1:0] wdata;
  } ex_req_t;

  // one request on the data bus
  typedef struct packed {
    logic [`LSU_DATA_W-1:0] addr;
    logic                   we;
    logic [`LSU_BE_W-1:0]   be;
    logic [`LSU_DATA_W-1:0] wdata;
  } bus_req_t;

  // per-access info kept until the response comes back
  typedef struct packed {
    logic                   we;
    data_type_e             dtype;
    ext_mode_e              ext;
    logic [`LSU_OFFS_W-1:0] offset;
  } wb_ctrl_t;

endpackage

// File: logic/lsu_req_format.sv
// lsu request formatter
// forms the address, the byte enables and the lane-rotated store data

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_req_format (
  input  logic               ex_valid_i,  // only qualifies the alignment check
  input  lsu_pkg::ex_req_t   ex_req_i,
  output lsu_pkg::bus_req_t  bus_req_o,
  output lsu_pkg::wb_ctrl_t  wb_ctrl_o
);

  logic [`LSU_DATA_W-1:0] addr;
  logic [`LSU_OFFS_W-1:0] offset;
  logic [`LSU_BE_W-1:0]   be;
  logic [`LSU_DATA_W-1:0] wdata_rot;

  assign addr   = ex_req_i.use_incr ? (ex_req_i.op_a + ex_req_i.op_b) : ex_req_i.op_a;
  assign offset = addr[`LSU_OFFS_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    case (ex_req_i.dtype)
      lsu_pkg::dt_word: be = 4'b1111;
      lsu_pkg::dt_half: be = 4'b0011 << offset;  // lanes offset, offset+1
      default:          be = 4'b0001 << offset;  // single byte lane
    endcase
  end

  // store data: byte 0 lands in lane offset
  always_comb
  begin
    case (offset)
      2'd0:    wdata_rot = ex_req_i.wdata;
      2'd1:    wdata_rot = {ex_req_i.wdata[23:0], ex_req_i.wdata[31:24]};
      2'd2:    wdata_rot = {ex_req_i.wdata[15:0], ex_req_i.wdata[31:16]};
      default: wdata_rot = {ex_req_i.wdata[7:0], ex_req_i.wdata[31:8]};
    endcase
  end

  assign bus_req_o.addr  = addr;
  assign bus_req_o.we    = ex_req_i.we;
  assign bus_req_o.be    = be;
  assign bus_req_o.wdata = wdata_rot;

  // what the read path needs once the response arrives
  assign wb_ctrl_o.we     = ex_req_i.we;
  assign wb_ctrl_o.dtype  = ex_req_i.dtype;
  assign wb_ctrl_o.ext    = ex_req_i.ext;
  assign wb_ctrl_o.offset = offset;

  // no second phase exists, so a request crossing a word boundary is illegal
  always_comb
  begin
    a_no_misaligned: assert #0 (!ex_valid_i ||
      !((ex_req_i.dtype == lsu_pkg::dt_word && offset != 2'd0) ||
        (ex_req_i.dtype == lsu_pkg::dt_half && offset == 2'd3)))
      else $error("misaligned lsu request at %h", addr);
  end

endmodule

// File: logic/lsu_trans_ctrl.sv
// lsu transaction tracker
// counts outstanding accesses, decides issue and keeps per-access
// read-path info in an in-order queue

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_trans_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ex_valid_i,
  input  logic               port_ready_i,  // bus port can take a request
  input  logic               rvalid_i,
  input  logic               port_busy_i,
  input  lsu_pkg::wb_ctrl_t  wb_ctrl_i,
  output logic               issue_o,
  output logic               ready_ex_o,
  output logic               ready_wb_o,
  output logic               busy_o,
  output lsu_pkg::wb_ctrl_t  wb_ctrl_o,     // queue head
  output logic               load_rvalid_o
);

  localparam int PTR_W = $clog2(`LSU_MAX_OUTSTANDING);  // depth is a power of two

  logic [`LSU_CNT_W-1:0] cnt_q;
  logic [`LSU_CNT_W-1:0] cnt_d;
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  lsu_pkg::wb_ctrl_t     queue_q [`LSU_MAX_OUTSTANDING];

  //////////////////////////////////////////////////////////////////////
  // issue and handshake decisions
  //////////////////////////////////////////////////////////////////////
  assign issue_o    = ex_valid_i && (cnt_q < `LSU_CNT_W'(`LSU_MAX_OUTSTANDING)) && port_ready_i;
  assign ready_ex_o = !ex_valid_i || issue_o;                   // consumed on issue
  assign ready_wb_o = (cnt_q == '0) ? 1'b1 : rvalid_i;
  assign busy_o     = (cnt_q != '0) || port_busy_i;

  // issue and response together leave the count as it is
  always_comb
  begin
    cnt_d = cnt_q;
    if (issue_o && !rvalid_i)
      cnt_d = cnt_q + 1'b1;
    else if (!issue_o && rvalid_i)
      cnt_d = cnt_q - 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      cnt_q <= cnt_d;
      if (issue_o)
        wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at depth
      if (rvalid_i)
        rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // queue entries, pushed in issue order
  always_ff @(posedge clk)
  begin
    if (issue_o)
      queue_q[wr_ptr_q] <= wb_ctrl_i;
  end

  assign wb_ctrl_o     = queue_q[rd_ptr_q];
  assign load_rvalid_o = rvalid_i && !wb_ctrl_o.we;  // stores return no data

  //////////////////////////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////////////////////////
  // the memory only answers requests this unit issued
  a_no_spurious_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> (cnt_q != '0));

  a_cnt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= `LSU_CNT_W'(`LSU_MAX_OUTSTANDING));

endmodule

// File: logic/lsu_bus_port.sv
// lsu bus port
// registers an issued request and holds it on the bus until granted

`timescale 1ns/1ps

module lsu_bus_port (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               issue_i,
  input  lsu_pkg::bus_req_t  req_i,
  output logic               port_ready_o,  // idle or granted this cycle
  output logic               port_busy_o,
  output logic               bus_req_o,
  input  logic               bus_gnt_i,
  output lsu_pkg::bus_req_t  bus_o
);

  lsu_pkg::port_state_e state_q;
  lsu_pkg::port_state_e state_d;
  lsu_pkg::bus_req_t    req_q;

  // a grant frees the register in the same cycle
  assign port_ready_o = (state_q == lsu_pkg::port_idle) || bus_gnt_i;

  //////////////////////////////////////////////////////////////////////
  // request FSM
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      lsu_pkg::port_idle:
      begin
        if (issue_i)
          state_d = lsu_pkg::port_wait_gnt;
      end
      default:
      begin
        if (bus_gnt_i && !issue_i)
          state_d = lsu_pkg::port_idle;  // chained issue keeps us waiting
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= lsu_pkg::port_idle;
    else
      state_q <= state_d;
  end

  // request register, only written when the port is free
  always_ff @(posedge clk)
  begin
    if (issue_i)
      req_q <= req_i;
  end

  assign bus_req_o   = (state_q == lsu_pkg::port_wait_gnt);
  assign port_busy_o = (state_q == lsu_pkg::port_wait_gnt);
  assign bus_o       = req_q;

  // an ungranted request stays on the bus unchanged
  a_hold_until_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_req_o && !bus_gnt_i) |=> (bus_req_o && $stable(bus_o)));

endmodule

// File: logic/lsu_rdata_align.sv
// lsu read-data aligner
// picks the loaded field out of the response word, extends it to a word
// and holds the last load result for the execute stage

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_rdata_align (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rvalid_i,
  input  logic                   load_rvalid_i,  // rvalid of a load
  input  logic [`LSU_DATA_W-1:0] rdata_i,
  input  lsu_pkg::wb_ctrl_t      wb_ctrl_i,
  output logic [`LSU_DATA_W-1:0] rdata_ex_o
);

  logic [`LSU_DATA_W-1:0] rdata_sh;  // field moved down to lane 0
  logic [`LSU_DATA_W-1:0] rdata_ext;
  logic [`LSU_DATA_W-1:0] rdata_q;
  logic                   fill_h;    // fill bit above a half
  logic                   fill_b;    // fill bit above a byte

  assign rdata_sh = rdata_i >> {wb_ctrl_i.offset, 3'b000};

  //////////////////////////////////////////////////////////////////////
  // extension
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    case (wb_ctrl_i.ext)
      lsu_pkg::ext_sign:
      begin
        fill_h = rdata_sh[15];
        fill_b = rdata_sh[7];
      end
      lsu_pkg::ext_ones:
      begin
        fill_h = 1'b1;
        fill_b = 1'b1;
      end
      default:
      begin
        fill_h = 1'b0;
        fill_b = 1'b0;
      end
    endcase
  end

  always_comb
  begin
    case (wb_ctrl_i.dtype)
      lsu_pkg::dt_word: rdata_ext = rdata_i;  // always aligned
      lsu_pkg::dt_half: rdata_ext = {{16{fill_h}}, rdata_sh[15:0]};
      default:          rdata_ext = {{24{fill_b}}, rdata_sh[7:0]};
    endcase
  end

  // hold register, keeps the last load result
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (load_rvalid_i)
      rdata_q <= rdata_ext;
  end

  assign rdata_ex_o = rvalid_i ? rdata_ext : rdata_q;  // live in the rvalid cycle

endmodule

// File: logic/lsu_top.sv
// lsu top level
// load/store unit between the execute stage and a req/gnt/rvalid data bus

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // execute stage
  input  logic                   ex_valid_i,
  input  lsu_pkg::ex_req_t       ex_req_i,
  output logic                   ready_ex_o,
  output logic                   ready_wb_o,
  output logic                   busy_o,
  output logic [`LSU_DATA_W-1:0] rdata_ex_o,
  // data bus
  output logic                   bus_req_o,
  input  logic                   bus_gnt_i,
  output lsu_pkg::bus_req_t      bus_o,
  input  logic                   bus_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] bus_rdata_i
);

  lsu_pkg::bus_req_t fmt_req;      // formatted request
  lsu_pkg::wb_ctrl_t fmt_ctrl;     // read-path info of that request
  lsu_pkg::wb_ctrl_t head_ctrl;    // info of the oldest outstanding access
  logic              issue;
  logic              port_ready;
  logic              port_busy;
  logic              load_rvalid;

  //////////////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////////////
  lsu_req_format u_req_format (
    .ex_valid_i (ex_valid_i),
    .ex_req_i   (ex_req_i),
    .bus_req_o  (fmt_req),
    .wb_ctrl_o  (fmt_ctrl)
  );

  lsu_trans_ctrl u_trans_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .ex_valid_i    (ex_valid_i),
    .port_ready_i  (port_ready),
    .rvalid_i      (bus_rvalid_i),
    .port_busy_i   (port_busy),
    .wb_ctrl_i     (fmt_ctrl),
    .issue_o       (issue),
    .ready_ex_o    (ready_ex_o),
    .ready_wb_o    (ready_wb_o),
    .busy_o        (busy_o),
    .wb_ctrl_o     (head_ctrl),
    .load_rvalid_o (load_rvalid)
  );

  lsu_bus_port u_bus_port (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_i      (issue),
    .req_i        (fmt_req),
    .port_ready_o (port_ready),
    .port_busy_o  (port_busy),
    .bus_req_o    (bus_req_o),
    .bus_gnt_i    (bus_gnt_i),
    .bus_o        (bus_o)
  );

  // response side
  lsu_rdata_align u_rdata_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .rvalid_i      (bus_rvalid_i),
    .load_rvalid_i (load_rvalid),
    .rdata_i       (bus_rdata_i),
    .wb_ctrl_i     (head_ctrl),
    .rdata_ex_o    (rdata_ex_o)
  );

endmodule

// File: dv/lsu_tb_tasks.svh
// lsu testbench tasks
// expected-value rules, driver, waits, compares and the directed tests

`ifndef LSU_TB_TASKS_SVH
`define LSU_TB_TASKS_SVH

// pattern over the whole word index
function automatic logic [31:0] fill_word(input int idx);
  return (idx * 32'h0101_0101) ^ 32'hc3a5_5a3c;
endfunction

// no word off zero, no half crossing the word
function automatic bit legal_offset(input int dt, input int off);
  return !((dt == 0 && off != 0) || (dt == 1 && off == 3));
endfunction

function automatic lsu_pkg::bus_req_t expect_bus(input lsu_pkg::ex_req_t r);
  lsu_pkg::bus_req_t b;
  int                sh;
  b.addr = r.use_incr ? r.op_a + r.op_b : r.op_a;
  sh     = 8 * b.addr[1:0];
  b.we   = r.we;
  case (r.dtype)
    lsu_pkg::dt_word: b.be = 4'b1111;
    lsu_pkg::dt_half: b.be = 4'b0011 << b.addr[1:0];
    default:          b.be = 4'b0001 << b.addr[1:0];
  endcase
  b.wdata = (r.wdata << sh) | (r.wdata >> (32 - sh));  // rotate left, byte 0 to lane off
  return b;
endfunction

function automatic logic [31:0] expect_load(input logic [31:0] word,
    input lsu_pkg::data_type_e dt, input lsu_pkg::ext_mode_e ext, input int off);
  logic [15:0] field;
  logic        fill;
  int          top;
  if (dt == lsu_pkg::dt_word)
    return word;
  top   = (dt == lsu_pkg::dt_half) ? 15 : 7;
  field = (dt == lsu_pkg::dt_half) ? word[8*off +: 16] : {8'h00, word[8*off +: 8]};
  fill  = (ext == lsu_pkg::ext_ones) || (ext == lsu_pkg::ext_sign && field[top]);
  if (dt == lsu_pkg::dt_half)
    return {{16{fill}}, field};
  return {{24{fill}}, field[7:0]};
endfunction

//////////////////////////////////////////////////////////////////////
// failure and compares
//////////////////////////////////////////////////////////////////////
task automatic abort_run(input string why);
  $display("%s", why);
  $display("sim failed");
  $fatal(1, "run stopped at the first error");
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  if (got !== exp)
    abort_run($sformatf("** Error @ %0t ns: %s is %b, expected %b", $time, what, got, exp));
endtask

task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp, input string what);
  if (got !== exp)
    abort_run($sformatf("** Error @ %0t ns: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_bus_req(input lsu_pkg::bus_req_t got, input lsu_pkg::bus_req_t exp,
    input string what);
  if (got !== exp)
    abort_run($sformatf("** Error @ %0t ns: %s addr %h we %b be %b wdata %h, expected %h %b %b %h",
      $time, what, got.addr, got.we, got.be, got.wdata, exp.addr, exp.we, exp.be, exp.wdata));
endtask

// memory side of a granted request, stores write only the enabled lanes
task automatic serve(input lsu_pkg::bus_req_t req);
  int w;
  w = req.addr[7:2];  // 64 words
  if (req.we)
  begin
    for (int b = 0; b < 4; b++)
      if (req.be[b])
        mem[w][8*b +: 8] = req.wdata[8*b +: 8];
  end
  rsp_data.push_back(mem[w]);
  rsp_wait.push_back(rsp_dly);
  if (rand_dly)
  begin
    gnt_dly = {$random(seed)} % 4;  // 0..3 cycles before the next grant
    rsp_dly = {$random(seed)} % 4;
  end
endtask

// called 2 ns after an edge, returns at the same phase
task automatic issue_access(input lsu_pkg::ex_req_t req, input logic [31:0] exp_rdata);
  int n;
  n          = 0;
  ex_req_i   = req;
  ex_valid_i = 1'b1;
  @(negedge clk);
  while (!ready_ex_o)
  begin
    n++;
    if (n > TMO)
      abort_run("timed out waiting for ready_ex_o");
    @(negedge clk);
  end
  @(posedge clk);
  #2;
  ex_valid_i = 1'b0;
  exp_q.push_back({!req.we, exp_rdata});
  check_flag(bus_req_o, 1'b1, "bus_req_o one cycle after issue");
  check_bus_req(bus_o, expect_bus(req), "issued request");
endtask

task automatic wait_idle();
  int n;
  n = 0;
  @(negedge clk);
  while (busy_o || bus_req_o)
  begin
    n++;
    if (n > TMO)
      abort_run("timed out waiting for the unit to go idle");
    @(negedge clk);
  end
  @(posedge clk);
  #2;
  if (exp_q.size() != 0)
    abort_run("the unit went idle with accesses still unanswered");
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////
task automatic reset_values();
  @(negedge clk);
  check_flag(bus_req_o, 1'b0, "bus_req_o after reset");
  check_flag(busy_o, 1'b0, "busy_o after reset");
  check_flag(ready_ex_o, 1'b1, "ready_ex_o with no request");
  @(posedge clk);
  #2;
endtask

task automatic store_format();
  lsu_pkg::ex_req_t r;
  logic [31:0]      target;
  for (int dt = 0; dt < 3; dt++)
    for (int off = 0; off < 4; off++)
      for (int inc = 0; inc < 2; inc++)
      begin
        if (!legal_offset(dt, off))
          continue;
        target     = 32'h40 + 4 * dt + off;
        r          = '0;
        r.we       = 1'b1;
        r.dtype    = lsu_pkg::data_type_e'(dt);
        r.use_incr = inc[0];
        r.op_a     = inc[0] ? target - 32'h1c : target;
        r.op_b     = inc[0] ? 32'h1c : 32'hdead_0000;  // must be ignored without incr
        r.wdata    = 32'h1a2b_3c4d + target;
        issue_access(r, '0);
        wait_idle();
      end
endtask

task automatic load_extension();
  lsu_pkg::ex_req_t r;
  logic [31:0]      known;
  known   = 32'h80f1_7e02;  // both signs in bytes and halves
  r       = '0;
  r.we    = 1'b1;
  r.op_a  = 32'h20;
  r.wdata = known;
  issue_access(r, '0);
  wait_idle();
  for (int dt = 0; dt < 3; dt++)
    for (int off = 0; off < 4; off++)
      for (int e = 0; e < 3; e++)
      begin
        if (!legal_offset(dt, off))
          continue;
        r       = '0;
        r.dtype = lsu_pkg::data_type_e'(dt);
        r.ext   = lsu_pkg::ext_mode_e'(e);
        r.op_a  = 32'h20 + off;
        issue_access(r, expect_load(known, r.dtype, r.ext, off));
        wait_idle();
      end
endtask

task automatic backpressure_order();
  lsu_pkg::ex_req_t r;
  int               idx;
  rand_dly = 1'b1;
  for (int round = 0; round < 4; round++)
  begin
    for (int k = 0; k < 3; k++)  // word, half at 1, byte at 2
    begin
      idx     = 48 + 3 * round + k;
      r       = '0;
      r.dtype = lsu_pkg::data_type_e'(k);
      r.ext   = lsu_pkg::ext_mode_e'((k + round) % 3);
      r.op_a  = 4 * idx + k;
      issue_access(r, expect_load(fill_word(idx), r.dtype, r.ext, k));
    end
    wait_idle();
  end
  rand_dly = 1'b0;
  gnt_dly  = 0;
  rsp_dly  = 0;
endtask

task automatic busy_tracking();
  lsu_pkg::ex_req_t r;
  gnt_dly = 2;
  rsp_dly = 3;
  r       = '0;
  r.we    = 1'b1;
  r.dtype = lsu_pkg::dt_byte;
  r.op_a  = 32'h24;
  r.wdata = 32'h0000_005a;
  issue_access(r, '0);
  check_flag(busy_o, 1'b1, "busy_o after first issue");
  r.we  = 1'b0;
  r.ext = lsu_pkg::ext_sign;
  issue_access(r, expect_load(32'h0000_005a, lsu_pkg::dt_byte, lsu_pkg::ext_sign, 0));
  wait_idle();
  check_flag(busy_o, 1'b0, "busy_o after last rvalid");
  gnt_dly = 0;
  rsp_dly = 0;
endtask

`endif

// File: dv/lsu_tb.sv
// lsu testbench
// clock, reset, bus memory model and a response monitor around the lsu

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_tb;

  localparam int TMO = 200;  // cycles any single wait may take

  logic                   clk;
  logic                   rst_n;
  logic                   ex_valid_i;
  lsu_pkg::ex_req_t       ex_req_i;
  logic                   ready_ex_o;
  logic                   ready_wb_o;
  logic                   busy_o;
  logic [`LSU_DATA_W-1:0] rdata_ex_o;
  logic                   bus_req_o;
  logic                   bus_gnt_i;
  lsu_pkg::bus_req_t      bus_o;
  logic                   bus_rvalid_i;
  logic [`LSU_DATA_W-1:0] bus_rdata_i;

  // memory model
  logic [31:0]       mem [64];
  logic [31:0]       rsp_data [$];  // answers in grant order
  int                rsp_wait [$];  // cycles left before each answer
  int                gnt_dly;
  int                rsp_dly;
  int                gnt_cnt;
  logic              rand_dly;      // redraw delays on every grant
  integer            seed;
  logic              held;          // request seen without grant last cycle
  lsu_pkg::bus_req_t held_req;

  // scoreboard
  logic [32:0] exp_q [$];           // {is_load, expected result}
  logic [31:0] held_data;
  int          outst;               // accepted accesses without rvalid
  logic        chk_en;

  lsu_top u_lsu_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_valid_i   (ex_valid_i),
    .ex_req_i     (ex_req_i),
    .ready_ex_o   (ready_ex_o),
    .ready_wb_o   (ready_wb_o),
    .busy_o       (busy_o),
    .rdata_ex_o   (rdata_ex_o),
    .bus_req_o    (bus_req_o),
    .bus_gnt_i    (bus_gnt_i),
    .bus_o        (bus_o),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_rdata_i  (bus_rdata_i)
  );

  `include "lsu_tb_tasks.svh"

  always #10 clk = ~clk;  // 20 ns period

  //////////////////////////////////////////////////////////////////////
  // bus memory model, drives 2 ns after the edge
  //////////////////////////////////////////////////////////////////////
  always
  begin
    @(posedge clk);
    #2;
    bus_gnt_i    = 1'b0;
    bus_rvalid_i = 1'b0;
    if (rsp_wait.size() > 0)  // only the head counts down
    begin
      if (rsp_wait[0] == 0)
      begin
        bus_rvalid_i = 1'b1;
        bus_rdata_i  = rsp_data.pop_front();
        void'(rsp_wait.pop_front());
      end
      else
        rsp_wait[0] = rsp_wait[0] - 1;
    end
    if (held)
    begin
      check_flag(bus_req_o, 1'b1, "bus_req_o before grant");
      check_bus_req(bus_o, held_req, "request held for grant");
    end
    held = 1'b0;
    if (bus_req_o)
    begin
      if (gnt_cnt >= gnt_dly)
      begin
        bus_gnt_i = 1'b1;
        gnt_cnt   = 0;
        serve(bus_o);
      end
      else
      begin
        gnt_cnt  = gnt_cnt + 1;
        held     = 1'b1;
        held_req = bus_o;
      end
    end
  end

  // response monitor, samples mid-cycle
  always @(negedge clk)
  begin
    if (chk_en)
    begin
      check_flag(busy_o, (outst != 0) || bus_req_o, "busy_o");
      check_flag(ready_wb_o, (outst == 0) || bus_rvalid_i, "ready_wb_o");
      if (bus_rvalid_i && exp_q.size() == 0)
        abort_run("rvalid arrived with no access outstanding");
      else if (bus_rvalid_i)
      begin
        if (exp_q[0][32])
        begin
          check_rdata(rdata_ex_o, exp_q[0][31:0], "load result in rvalid cycle");
          held_data = exp_q[0][31:0];
        end
        void'(exp_q.pop_front());
      end
      else
        check_rdata(rdata_ex_o, held_data, "held load result");
      if (ex_valid_i && ready_ex_o && outst >= `LSU_MAX_OUTSTANDING)
        abort_run("an access was issued with the maximum already outstanding");
      if (ex_valid_i && ready_ex_o)
        outst = outst + 1;
      if (bus_rvalid_i)
        outst = outst - 1;
    end
  end

  initial
  begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    ex_valid_i   = 1'b0;
    ex_req_i     = '0;
    bus_gnt_i    = 1'b0;
    bus_rvalid_i = 1'b0;
    bus_rdata_i  = '0;
    seed         = 88219;
    gnt_dly      = 0;
    rsp_dly      = 0;
    gnt_cnt      = 0;
    rand_dly     = 1'b0;
    held         = 1'b0;
    held_req     = '0;
    held_data    = '0;  // hold register resets to zero
    outst        = 0;
    chk_en       = 1'b0;
    for (int i = 0; i < 64; i++)
      mem[i] = fill_word(i);
    repeat (2) @(posedge clk);
    #2;
    rst_n  = 1'b1;
    chk_en = 1'b1;
    reset_values();
    store_format();
    load_extension();
    backpressure_order();
    busy_tracking();
    $display("sim passed");
    $finish;
  end

endmodule

// File: all.f
+incdir+logic
+incdir+dv
logic/lsu_pkg.sv
logic/lsu_req_format.sv
logic/lsu_trans_ctrl.sv
logic/lsu_bus_port.sv
logic/lsu_rdata_align.sv
logic/lsu_top.sv
dv/lsu_tb.sv
